/* Bender.yml */
package:
  name: gba_mem

sources:
  - gba_mem_map_pkg.sv
  - gba_bus_pkg.sv
  - mem_port_if.sv
  - dual_port_bank.sv
  - system_rom.sv
  - bus_write_stage.sv
  - bus_region_router.sv
  - gba_mem_top.sv
  - target: test
    files:
      - gba_mem_props.sv
      - tb_gba_mem_top.sv

/* bios.hex */
// One 32-bit hex word per line, boot ROM word index 0 upward.
ea000018
ea000004
ea00004c
ea000002
ea000001
ea000000
ea000042
ea000034
e129f000
e3a0d0d3
e59fd0d0
e3a0e000
e12ff11e
e1a0c00e
e3a00001
cafe0f0f

/* bus_region_router.sv */
/* Region decode for the bus. Unmapped addresses read as zero and ROM or
   unmapped writes are dropped. No mirroring of any window. */

`timescale 1ns/1ps

module bus_region_router
    import gba_mem_map_pkg::*;
    import gba_bus_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic [31:0]                  bus_addr,
    input  logic [data_width-1:0]        bus_wdata,
    input  logic [31:0]                  wr_addr,
    input  logic [lane_count-1:0]        wr_lanes,
    input  logic                         wr_active,
    output logic [$clog2(rom_words)-1:0] rom_addr,
    input  logic [data_width-1:0]        rom_rdata,
    mem_port_if.master                   iwram,
    mem_port_if.master                   pal,
    mem_port_if.master                   vram,
    mem_port_if.master                   oam,
    output logic [data_width-1:0]        bus_rdata
);

    bus_addr_u   mem_addr;
    logic [31:0] rom_off, iwram_off, pal_off, vram_off, oam_off;
    logic        rom_hit, iwram_hit, pal_hit, vram_hit, oam_hit;
    logic [4:0]  rd_sel;  // One-hot {oam, vram, pal, iwram, rom}.

    // Registered address wins for the commit cycle.
    assign mem_addr.flat = wr_active ? wr_addr : bus_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Region decode and range checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rom_hit   = (mem_addr.fields.region == rom_base[31:24]) &&
                       (mem_addr.fields.offset[23:2] < rom_words);
    assign iwram_hit = (mem_addr.fields.region == iwram_base[31:24]) &&
                       (mem_addr.fields.offset[23:2] < iwram_words);
    assign pal_hit   = (mem_addr.fields.region == pal_base[31:24]) &&
                       (mem_addr.fields.offset[23:2] < pal_words);
    assign vram_hit  = (mem_addr.fields.region == vram_base[31:24]) &&
                       (mem_addr.fields.offset[23:2] < vram_words);
    assign oam_hit   = (mem_addr.fields.region == oam_base[31:24]) &&
                       (mem_addr.fields.offset[23:2] < oam_words);

    // Region-relative byte offsets.
    assign rom_off   = mem_addr.flat - rom_base;
    assign iwram_off = mem_addr.flat - iwram_base;
    assign pal_off   = mem_addr.flat - pal_base;
    assign vram_off  = mem_addr.flat - vram_base;
    assign oam_off   = mem_addr.flat - oam_base;

    // ROM has no write lanes at all.
    assign rom_addr = rom_off[$clog2(rom_words)+1:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bank ports. Lanes reach only the hit bank.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign iwram.addr    = iwram_off[$clog2(iwram_words)+1:2];
    assign iwram.wdata   = bus_wdata;
    assign iwram.byte_we = iwram_hit ? wr_lanes : '0;
    assign iwram.rd      = iwram_hit;

    assign pal.addr    = pal_off[$clog2(pal_words)+1:2];
    assign pal.wdata   = bus_wdata;
    assign pal.byte_we = pal_hit ? wr_lanes : '0;
    assign pal.rd      = pal_hit;

    assign vram.addr    = vram_off[$clog2(vram_words)+1:2];
    assign vram.wdata   = bus_wdata;
    assign vram.byte_we = vram_hit ? wr_lanes : '0;
    assign vram.rd      = vram_hit;

    assign oam.addr    = oam_off[$clog2(oam_words)+1:2];
    assign oam.wdata   = bus_wdata;
    assign oam.byte_we = oam_hit ? wr_lanes : '0;
    assign oam.rd      = oam_hit;

    // Read select follows the banks' one-cycle latency.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_sel <= '0;
        end else begin
            rd_sel <= {oam_hit, vram_hit, pal_hit, iwram_hit, rom_hit};
        end
    end

    always_comb begin
        if (rd_sel[0])      bus_rdata = rom_rdata;
        else if (rd_sel[1]) bus_rdata = iwram.rdata;
        else if (rd_sel[2]) bus_rdata = pal.rdata;
        else if (rd_sel[3]) bus_rdata = vram.rdata;
        else if (rd_sel[4]) bus_rdata = oam.rdata;
        else                bus_rdata = '0;  // Unmapped.
    end

endmodule

/* bus_write_stage.sv */
/* Write capture for the CPU/DMA bus. Each accepted write pauses the bus for
   one cycle and the master must hold its inputs, data included. */

`timescale 1ns/1ps

module bus_write_stage
    import gba_bus_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [31:0]           bus_addr,
    input  logic [1:0]            bus_size,
    input  logic                  bus_write,
    output logic                  pause,
    output logic [31:0]           wr_addr,
    output logic [lane_count-1:0] wr_lanes,
    output logic                  wr_active
);

    logic [1:0] wr_size;
    logic       accept;

    // No write is taken while paused, so writes alternate with pauses.
    assign accept = bus_write & ~wr_active;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered write strobe and payload.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_active <= 1'b0;
        end else begin
            wr_active <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            wr_addr <= bus_addr;
            wr_size <= bus_size;
        end
    end

    // The pause cycle is the commit cycle.
    assign pause = wr_active;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-lane decode, little endian.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        wr_lanes = '0;
        if (wr_active) begin
            case (wr_size)
                size_byte: wr_lanes[wr_addr[1:0]] = 1'b1;
                size_half: wr_lanes = wr_addr[1] ? 4'b1100 : 4'b0011;
                size_word: wr_lanes = '1;
                default:   wr_lanes = '0;  // Reserved code writes nothing.
            endcase
        end
    end

endmodule

/* dual_port_bank.sv */
/* Behavioural dual-port RAM, zero at start of simulation. Port B is read
   only; indices past the depth read as zero. */

`timescale 1ns/1ps

module dual_port_bank
    import gba_bus_pkg::*;
#(
    parameter int depth_words = 256
) (
    input  logic                           clock,
    mem_port_if.slave                      port,
    input  logic [$clog2(depth_words)-1:0] b_addr,
    output logic [data_width-1:0]          b_rdata
);

    logic [data_width-1:0] mem [depth_words];

    initial begin
        for (int i = 0; i < depth_words; i++) begin
            mem[i] = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-lane writes from the bus side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clock) begin
        for (int lane = 0; lane < lane_count; lane++) begin
            if (port.byte_we[lane]) begin
                mem[port.addr][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
            end
        end
    end

    // Bus read returns the word as it was before this edge.
    always_ff @(posedge clock) begin
        if (port.rd) begin
            port.rdata <= mem[port.addr];
        end
    end

    // Graphics read, free running.
    always_ff @(posedge clock) begin
        if (b_addr < depth_words) begin
            b_rdata <= mem[b_addr];
        end else begin
            b_rdata <= '0;  // Gap at the top of VRAM.
        end
    end

endmodule

/* flist.f */
gba_mem_map_pkg.sv
gba_bus_pkg.sv
mem_port_if.sv
dual_port_bank.sv
system_rom.sv
bus_write_stage.sv
bus_region_router.sv
gba_mem_top.sv
gba_mem_props.sv
tb_gba_mem_top.sv

/* gba_bus_pkg.sv */
/* Bus access encodings. Data is little endian and aligned; the CPU side
   does any rotation of misaligned values. */

package gba_bus_pkg;

    // Access size codes on bus_size.
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;  // Code 3 is unused.

    // Data path geometry.
    localparam int data_width = 32;
    localparam int lane_count = 4;  // One enable per byte.

endpackage

/* gba_mem_map_pkg.sv */
/* Region windows for the on-chip memories. No mirroring and no cartridge space,
   so anything outside these windows is unmapped. */

package gba_mem_map_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte base addresses.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] rom_base   = 32'h0000_0000;
    localparam logic [31:0] iwram_base = 32'h0300_0000;
    localparam logic [31:0] pal_base   = 32'h0500_0000;
    localparam logic [31:0] vram_base  = 32'h0600_0000;
    localparam logic [31:0] oam_base   = 32'h0700_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Region depths in 32-bit words.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int rom_words   = 4096;   // 16 KiB boot ROM.
    localparam int iwram_words = 8192;   // 32 KiB work RAM.
    localparam int pal_words   = 256;    // 1 KiB palette.
    localparam int vram_words  = 24576;  // 96 KiB, not a power of two.
    localparam int oam_words   = 256;    // 1 KiB sprite attributes.

    // Region selector in the top byte, byte offset below it.
    typedef struct packed {
        logic [7:0]  region;
        logic [23:0] offset;
    } bus_addr_fields_t;

    // One bus address, seen flat for arithmetic or split for decoding.
    typedef union packed {
        logic [31:0]      flat;
        bus_addr_fields_t fields;
    } bus_addr_u;

endpackage

/* gba_mem_props.sv */
/* Checker bound into gba_mem_top. Keeps its own model of every region and
   expects the master to hold all bus inputs through each pause cycle. */

`timescale 1ns/1ps

module gba_mem_props
    import gba_mem_map_pkg::*;
    import gba_bus_pkg::*;
(
    input logic                  clock,
    input logic                  reset,
    input logic [31:0]           bus_addr,
    input logic [data_width-1:0] bus_wdata,
    input logic [1:0]            bus_size,
    input logic                  bus_write,
    input logic [data_width-1:0] bus_rdata,
    input logic                  bus_pause,
    input logic [31:0]           gfx_oam_addr,
    input logic [31:0]           gfx_pal_addr,
    input logic [31:0]           gfx_vram_addr,
    input logic [data_width-1:0] gfx_oam_data,
    input logic [data_width-1:0] gfx_pal_data,
    input logic [data_width-1:0] gfx_vram_data
);

    int                    error_count = 0;  // Watched by the testbench.
    logic [31:0]           rom_image [rom_words];
    logic [31:0]           ram_model [logic [29:0]];  // Keyed by word address.
    logic [31:0]           acc_addr;
    logic [1:0]            acc_size;
    logic                  read_chk_q, gfx_chk_q;
    logic [data_width-1:0] exp_bus_q, exp_pal_q, exp_vram_q, exp_oam_q;

    initial begin
        for (int i = 0; i < rom_words; i++) begin
            rom_image[i] = '0;
        end
        $readmemh("bios.hex", rom_image);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 0 for unmapped, else 1 + index in {rom, iwram, pal, vram, oam}.
    function automatic int region_of(logic [31:0] addr);
        bus_addr_u   a;
        logic [31:0] bases [5];
        int          depths [5];
        a.flat = addr;
        bases  = '{rom_base, iwram_base, pal_base, vram_base, oam_base};
        depths = '{rom_words, iwram_words, pal_words, vram_words, oam_words};
        for (int i = 0; i < 5; i++) begin
            if ((a.fields.region == bases[i][31:24]) && (a.fields.offset[23:2] < depths[i])) begin
                return i + 1;
            end
        end
        return 0;
    endfunction

    function automatic logic [31:0] read_model(logic [31:0] addr);
        int region;
        region = region_of(addr);
        if (region == 1) return rom_image[addr[13:2]];
        if ((region > 1) && ram_model.exists(addr[31:2])) return ram_model[addr[31:2]];
        return '0;  // Unwritten RAM or unmapped.
    endfunction

    function automatic void write_model(logic [31:0] addr, logic [1:0] size, logic [31:0] data);
        int          nbytes;
        logic [31:0] word;
        if (region_of(addr) < 2) return;  // ROM and holes ignore writes.
        case (size)
            size_byte: nbytes = 1;
            size_half: nbytes = 2;
            size_word: nbytes = 4;
            default:   nbytes = 0;  // Reserved code stores nothing.
        endcase
        word = read_model(addr);
        // A store covers the aligned group of nbytes bytes holding addr.
        for (int i = 0; i < lane_count; i++) begin
            if ((nbytes != 0) && (i / nbytes == addr[1:0] / nbytes)) begin
                word[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        ram_model[addr[31:2]] = word;
    endfunction

    // Expected values use the model before this edge's commit.
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            read_chk_q <= 1'b0;
            gfx_chk_q  <= 1'b0;
        end else begin
            read_chk_q <= !bus_write && !bus_pause;  // Plain read cycles only.
            gfx_chk_q  <= 1'b1;
            exp_bus_q  <= read_model(bus_addr);
            exp_pal_q  <= read_model(pal_base + gfx_pal_addr);
            exp_vram_q <= read_model(vram_base + gfx_vram_addr);
            exp_oam_q  <= read_model(oam_base + gfx_oam_addr);
            if (bus_write && !bus_pause) begin
                acc_addr <= bus_addr;
                acc_size <= bus_size;
            end
            if (bus_pause) begin
                write_model(acc_addr, acc_size, bus_wdata);  // Data held by master.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Properties.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_pause: assert property (@(posedge clock) reset |-> !bus_pause)
        else begin
            error_count++;
            $error("bus_pause was high during reset at %0t", $time);
        end

    a_pause_rise: assert property (@(posedge clock) disable iff (reset)
        (bus_write && !bus_pause) |=> bus_pause)
        else begin
            error_count++;
            $error("bus_pause did not rise after an accepted write at %0t", $time);
        end

    a_pause_single: assert property (@(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause)
        else begin
            error_count++;
            $error("bus_pause stayed high for two cycles at %0t", $time);
        end

    a_bus_read: assert property (@(posedge clock) disable iff (reset)
        read_chk_q |-> (bus_rdata == exp_bus_q))
        else begin
            error_count++;
            $error("Mismatch at %0t: bus_rdata %h, expected %h", $time,
                   $sampled(bus_rdata), exp_bus_q);
        end

    a_gfx_pal: assert property (@(posedge clock) disable iff (reset)
        gfx_chk_q |-> (gfx_pal_data == exp_pal_q))
        else begin
            error_count++;
            $error("Mismatch at %0t: gfx_pal_data %h, expected %h", $time,
                   $sampled(gfx_pal_data), exp_pal_q);
        end

    a_gfx_vram: assert property (@(posedge clock) disable iff (reset)
        gfx_chk_q |-> (gfx_vram_data == exp_vram_q))
        else begin
            error_count++;
            $error("Mismatch at %0t: gfx_vram_data %h, expected %h", $time,
                   $sampled(gfx_vram_data), exp_vram_q);
        end

    a_gfx_oam: assert property (@(posedge clock) disable iff (reset)
        gfx_chk_q |-> (gfx_oam_data == exp_oam_q))
        else begin
            error_count++;
            $error("Mismatch at %0t: gfx_oam_data %h, expected %h", $time,
                   $sampled(gfx_oam_data), exp_oam_q);
        end

endmodule

/* gba_mem_top.sv */
/* On-chip memory subsystem. Bus writes pause one cycle; gfx addresses are
   region-relative bytes and their reads ignore the bus entirely. */

`timescale 1ns/1ps

module gba_mem_top
    import gba_mem_map_pkg::*;
    import gba_bus_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,

    // CPU/DMA bus.
    input  logic [31:0]           bus_addr,
    input  logic [data_width-1:0] bus_wdata,
    input  logic [1:0]            bus_size,
    input  logic                  bus_write,
    output logic [data_width-1:0] bus_rdata,
    output logic                  bus_pause,

    // Graphics pipeline, read only.
    input  logic [31:0]           gfx_oam_addr,
    input  logic [31:0]           gfx_pal_addr,
    input  logic [31:0]           gfx_vram_addr,
    output logic [data_width-1:0] gfx_oam_data,
    output logic [data_width-1:0] gfx_pal_data,
    output logic [data_width-1:0] gfx_vram_data
);

    logic [31:0]                  wr_addr;
    logic [lane_count-1:0]        wr_lanes;
    logic                         wr_active;
    logic [$clog2(rom_words)-1:0] rom_addr;
    logic [data_width-1:0]        rom_rdata;

    mem_port_if #(.depth_words(iwram_words)) iwram_if ();
    mem_port_if #(.depth_words(pal_words))   pal_if ();
    mem_port_if #(.depth_words(vram_words))  vram_if ();
    mem_port_if #(.depth_words(oam_words))   oam_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bus_write_stage write_stage_i (
        .clock,
        .reset,
        .bus_addr,
        .bus_size,
        .bus_write,
        .pause     (bus_pause),
        .wr_addr,
        .wr_lanes,
        .wr_active
    );

    bus_region_router router_i (
        .clock,
        .reset,
        .bus_addr,
        .bus_wdata,
        .wr_addr,
        .wr_lanes,
        .wr_active,
        .rom_addr,
        .rom_rdata,
        .iwram     (iwram_if.master),
        .pal       (pal_if.master),
        .vram      (vram_if.master),
        .oam       (oam_if.master),
        .bus_rdata
    );

    system_rom rom_i (
        .clock,
        .addr  (rom_addr),
        .rdata (rom_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Banks. Work RAM has no graphics reader.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dual_port_bank #(.depth_words(iwram_words)) iwram_i (
        .clock,
        .port    (iwram_if.slave),
        .b_addr  ('0),
        .b_rdata ()
    );

    dual_port_bank #(.depth_words(pal_words)) pal_i (
        .clock,
        .port    (pal_if.slave),
        .b_addr  (gfx_pal_addr[$clog2(pal_words)+1:2]),
        .b_rdata (gfx_pal_data)
    );

    dual_port_bank #(.depth_words(vram_words)) vram_i (
        .clock,
        .port    (vram_if.slave),
        .b_addr  (gfx_vram_addr[$clog2(vram_words)+1:2]),
        .b_rdata (gfx_vram_data)
    );

    dual_port_bank #(.depth_words(oam_words)) oam_i (
        .clock,
        .port    (oam_if.slave),
        .b_addr  (gfx_oam_addr[$clog2(oam_words)+1:2]),  // Own address.
        .b_rdata (gfx_oam_data)
    );

endmodule

/* mem_port_if.sv */
/* Bus-side port of one RAM bank. The word index is sized from the
   bank depth, so the instance parameter must match the bank. */

`timescale 1ns/1ps

interface mem_port_if
    import gba_bus_pkg::*;
#(
    parameter int depth_words = 256
) ();

    logic [$clog2(depth_words)-1:0] addr;     // Word index.
    logic [data_width-1:0]          wdata;
    logic [lane_count-1:0]          byte_we;  // Zero means no write.
    logic                           rd;
    logic [data_width-1:0]          rdata;    // Valid one cycle after rd.

    modport master (
        output addr,
        output wdata,
        output byte_we,
        output rd,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  byte_we,
        input  rd,
        output rdata
    );

endinterface

/* system_rom.sv */
/* Boot ROM with a registered read. Words past the end of bios.hex stay zero;
   the file must sit in the simulator's working directory. */

`timescale 1ns/1ps

module system_rom
    import gba_mem_map_pkg::*;
    import gba_bus_pkg::*;
(
    input  logic                         clock,
    input  logic [$clog2(rom_words)-1:0] addr,
    output logic [data_width-1:0]        rdata
);

    logic [data_width-1:0] mem [rom_words];

    initial begin
        for (int i = 0; i < rom_words; i++) begin
            mem[i] = '0;
        end
        $readmemh("bios.hex", mem);  // Partial image is fine.
    end

    always_ff @(posedge clock) begin
        rdata <= mem[addr];
    end

endmodule

/* tb_gba_mem_top.sv */
/* Testbench for gba_mem_top. Checking lives in the bound property module;
   this file only drives the bus and graphics ports and ends the run. */

`timescale 1ns/1ps

module tb_gba_mem_top
    import gba_mem_map_pkg::*;
    import gba_bus_pkg::*;
();

    localparam int timeout_cycles = 2000;  // About 1200 cycles of stimulus.

    logic        clock, reset;
    logic [31:0] bus_addr, bus_wdata, bus_rdata;
    logic [1:0]  bus_size;
    logic        bus_write, bus_pause;
    logic [31:0] gfx_oam_addr, gfx_pal_addr, gfx_vram_addr;
    logic [31:0] gfx_oam_data, gfx_pal_data, gfx_vram_data;
    logic [31:0] lcg_state = 32'h794ac636;
    int          cycle_count = 0;
    logic [31:0] ram_bases [4] = '{iwram_base, pal_base, vram_base, oam_base};

    bind gba_mem_top gba_mem_props props_i (.*);

    gba_mem_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Small word window per region, sometimes straddling the top edge.
    function automatic logic [31:0] pick_addr(logic [1:0] size);
        logic [31:0] r, base, word;
        logic [31:0] bases [8];
        int          depths [8];
        int          depth;
        r      = next_rand();
        bases  = '{rom_base, iwram_base, pal_base, vram_base,
                   oam_base, 32'h0400_0000, 32'h0800_0000, pal_base};  // 5 and 6 are holes.
        depths = '{rom_words, iwram_words, pal_words, vram_words,
                   oam_words, 256, 256, pal_words};
        base   = bases[r[30:28]];
        depth  = depths[r[30:28]];
        word = (r[19:18] == 2'd0) ? depth - 2 + r[17:16] : r[23:20];
        if (size == size_byte) return base + word * 4 + r[13:12];
        if (size == size_half) return base + word * 4 + {r[13], 1'b0};
        return base + word * 4;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus access tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_access(logic [31:0] addr, logic [1:0] size, logic [31:0] data);
        @(posedge clock);
        bus_addr  <= addr;
        bus_size  <= size;
        bus_wdata <= data;
        bus_write <= 1'b1;
        do @(negedge clock); while (!bus_pause);  // Hold through the pause.
        @(posedge clock);
        bus_write <= 1'b0;  // Next cycle reads the same address back.
        if ((addr[31:24] == 8'h05) && (addr[23:0] < 24'h400)) gfx_pal_addr <= addr[23:0];
        if ((addr[31:24] == 8'h06) && (addr[23:0] < 24'h20000)) gfx_vram_addr <= addr[23:0];
        if ((addr[31:24] == 8'h07) && (addr[23:0] < 24'h400)) gfx_oam_addr <= addr[23:0];
    endtask

    task automatic read_access(logic [31:0] addr);
        @(posedge clock);
        bus_addr  <= addr;
        bus_size  <= size_word;
        bus_write <= 1'b0;
    endtask

    // Stops at the first failed property or at the cycle limit.
    initial begin
        wait ((dut_i.props_i.error_count != 0) || (cycle_count >= timeout_cycles));
        if (dut_i.props_i.error_count != 0) begin
            $display("A property check failed at %0t", $time);
        end else begin
            $display("Timeout after %0d cycles before the test sequence ended", cycle_count);
        end
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped early");
    end

    initial begin
        logic [31:0] r, addr;
        logic [1:0]  size;
        bus_addr      = '0;
        bus_wdata     = '0;
        bus_size      = size_word;
        bus_write     = 1'b0;
        gfx_oam_addr  = '0;
        gfx_pal_addr  = '0;
        gfx_vram_addr = '0;
        reset         = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // Boot image, then a write that must be dropped.
        for (int i = 0; i < 16; i++) read_access(rom_base + i * 4);
        write_access(rom_base + 4, size_word, 32'hdead_beef);
        read_access(rom_base + 4);

        // Lane merges in every RAM.
        for (int i = 0; i < 4; i++) begin
            write_access(ram_bases[i], size_word, 32'h1122_3344);
            write_access(ram_bases[i] + 1, size_byte, 32'haaaa_aaaa);
            write_access(ram_bases[i] + 2, size_half, 32'h5566_7788);
            read_access(ram_bases[i]);
        end

        // Holes, including one that would alias palette word 0.
        write_access(32'h0400_0000, size_word, 32'h0bad_0bad);
        write_access(pal_base + 32'h400, size_word, 32'hffff_ffff);
        read_access(pal_base);

        for (int n = 0; n < 550; n++) begin
            r    = next_rand();
            size = (r[5:4] == 2'd3) ? size_word : r[5:4];
            addr = pick_addr(size);
            if (r[31]) write_access(addr, size, next_rand());
            else read_access(addr);
        end

        repeat (3) @(posedge clock);
        if (dut_i.props_i.error_count != 0) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "property checks failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
